//--- src.f
+incdir+logic
+incdir+dv
logic/alu_pkg.sv
logic/dec_exe_if.sv
logic/exe_res_if.sv
logic/alu_decode.sv
logic/alu_execute.sv
logic/alu_result.sv
logic/alu_core.sv
dv/alu_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the alu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module alu_core_tb -f src.f \
    --Mdir obj_dir -o alu_core_sim \
    && ./obj_dir/alu_core_sim | tee sim.log \
    && grep -q "ALL CHECKS PASSED" sim.log \
    || { echo "simulation failed"; exit 1; }
echo "simulation passed"

//--- dv/alu_tb_model.svh
`ifndef ALU_TB_MODEL_SVH
`define ALU_TB_MODEL_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

// expected data and illegal flag of one instruction, straight from RV64I
function automatic void predict(input logic [31:0] ins, input logic [63:0] pc,
                                input logic [63:0] x1, input logic [63:0] x2,
                                output logic [63:0] data, output logic illegal);
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    logic [31:0] w;
    logic        is_w;
    imm_i   = {{52{ins[31]}}, ins[31:20]};
    imm_u   = {{32{ins[31]}}, ins[31:12], 12'h000};
    data    = '0;
    w       = '0;
    is_w    = 1'b0;
    illegal = 1'b0;
    case (ins[6:0])
        `OPC_OP_IMM: begin
            case (ins[14:12])
                `F3_ADD:  data = x1 + imm_i;
                `F3_SLT:  data = {63'd0, $signed(x1) < $signed(imm_i)};
                `F3_SLTU: data = {63'd0, x1 < imm_i};
                `F3_XOR:  data = x1 ^ imm_i;
                `F3_OR:   data = x1 | imm_i;
                `F3_AND:  data = x1 & imm_i;
                `F3_SLL: begin
                    if (ins[31:26] == 6'h00)
                        data = x1 << ins[25:20];
                    else
                        illegal = 1'b1;
                end
                default: begin
                    if (ins[31:26] == 6'h00)
                        data = x1 >> ins[25:20];
                    else if (ins[31:26] == 6'h10)
                        data = $signed(x1) >>> ins[25:20];
                    else
                        illegal = 1'b1;
                end
            endcase
        end
        `OPC_OP: begin
            case ({ins[31:25], ins[14:12]})
                {`F7_BASE, `F3_ADD}:  data = x1 + x2;
                {`F7_ALT, `F3_ADD}:   data = x1 - x2;
                {`F7_BASE, `F3_SLL}:  data = x1 << x2[5:0];
                {`F7_BASE, `F3_SLT}:  data = {63'd0, $signed(x1) < $signed(x2)};
                {`F7_BASE, `F3_SLTU}: data = {63'd0, x1 < x2};
                {`F7_BASE, `F3_XOR}:  data = x1 ^ x2;
                {`F7_BASE, `F3_SR}:   data = x1 >> x2[5:0];
                {`F7_ALT, `F3_SR}:    data = $signed(x1) >>> x2[5:0];
                {`F7_BASE, `F3_OR}:   data = x1 | x2;
                {`F7_BASE, `F3_AND}:  data = x1 & x2;
                default:              illegal = 1'b1;
            endcase
        end
        `OPC_OP_IMM_32: begin
            is_w = 1'b1;
            case ({ins[31:25], ins[14:12]})
                {`F7_BASE, `F3_SLL}: w = x1[31:0] << ins[24:20];
                {`F7_BASE, `F3_SR}:  w = x1[31:0] >> ins[24:20];
                {`F7_ALT, `F3_SR}:   w = $signed(x1[31:0]) >>> ins[24:20];
                default: begin
                    // addiw keeps its immediate in the funct7 field
                    if (ins[14:12] == `F3_ADD)
                        w = x1[31:0] + imm_i[31:0];
                    else
                        illegal = 1'b1;
                end
            endcase
        end
        `OPC_OP_32: begin
            is_w = 1'b1;
            case ({ins[31:25], ins[14:12]})
                {`F7_BASE, `F3_ADD}: w = x1[31:0] + x2[31:0];
                {`F7_ALT, `F3_ADD}:  w = x1[31:0] - x2[31:0];
                {`F7_BASE, `F3_SLL}: w = x1[31:0] << x2[4:0];
                {`F7_BASE, `F3_SR}:  w = x1[31:0] >> x2[4:0];
                {`F7_ALT, `F3_SR}:   w = $signed(x1[31:0]) >>> x2[4:0];
                default:             illegal = 1'b1;
            endcase
        end
        `OPC_LUI:   data = imm_u;
        `OPC_AUIPC: data = pc + imm_u;
        default:    illegal = 1'b1;
    endcase
    if (illegal)
        data = '0;
    else if (is_w)
        data = {{32{w[31]}}, w};
endfunction

`endif

//--- dv/alu_core_tb.sv
`timescale 1ns/100ps
`include "alu_defines.svh"

module alu_core_tb
    import alu_pkg::*;
;
    // reg ops, imm ops, word ops, illegal, stream, back-pressure
    localparam int N_INSTR     = 30 + 19 + 18 + 9 + 21 + 27;
    localparam int CYCLE_LIMIT = 4 * N_INSTR + 100;
    localparam int N_BURST     = 20;
    localparam int N_BP_RAND   = 24;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic             in_ready;
    instr_u           in_instr;
    logic [`XLEN-1:0] in_pc;
    logic [`XLEN-1:0] in_rs1_data;
    logic [`XLEN-1:0] in_rs2_data;
    logic             out_valid;
    logic             out_ready;
    logic [4:0]       out_rd;
    logic             out_regwrite;
    logic [`XLEN-1:0] out_data;
    logic             out_illegal;

    int          seed = 32'h28b0_9d28;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          check_mark = 0;
    int          error_mark = 0;
    logic        stalled = 1'b0;
    logic [63:0] held_data;
    // rd, regwrite, illegal, data
    logic [70:0] exp_q[$];

    `include "alu_tb_model.svh"

    alu_core u_alu_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_instr     (in_instr),
        .in_pc        (in_pc),
        .in_rs1_data  (in_rs1_data),
        .in_rs2_data  (in_rs2_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_rd       (out_rd),
        .out_regwrite (out_regwrite),
        .out_data     (out_data),
        .out_illegal  (out_illegal)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [63:0] rnd64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic record_input();
        logic [63:0] d;
        logic        ill;
        logic [4:0]  rd;
        predict(in_instr, in_pc, in_rs1_data, in_rs2_data, d, ill);
        rd = in_instr[11:7];
        exp_q.push_back({rd, !ill && (rd != 5'd0), ill, d});
    endtask

    task automatic check_output();
        logic [70:0] e;
        if (exp_q.size() == 0) begin
            check_true(1'b0, "output transfer with no instruction pending");
        end else begin
            e = exp_q.pop_front();
            check_value("out_rd", 64'(e[70:66]), 64'(out_rd));
            check_value("out_regwrite", 64'(e[65]), 64'(out_regwrite));
            check_value("out_illegal", 64'(e[64]), 64'(out_illegal));
            check_value("out_data", e[63:0], out_data);
        end
    endtask

    // everything is stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (stalled) begin
                check_true(out_valid, "out_valid dropped while out_ready was low");
                check_value("out_data (held)", held_data, out_data);
            end
            if (out_valid && out_ready) begin
                check_output();
            end
            stalled   = out_valid && !out_ready;
            held_data = out_data;
            if (in_valid && in_ready) begin
                record_input();
            end
        end
    end

    // called 2 ns after a rising edge, returns 2 ns after the accepting edge
    task automatic issue(input logic [31:0] ins, input logic [63:0] pc,
                         input logic [63:0] a, input logic [63:0] b);
        in_valid    = 1'b1;
        in_instr    = ins;
        in_pc       = pc;
        in_rs1_data = a;
        in_rs2_data = b;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic issue_random(input logic [31:0] ins);
        logic [63:0] a;
        logic [63:0] b;
        a = rnd64();
        b = rnd64();
        issue(ins, 64'h1000, a, b);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || out_valid) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - check_mark,
                 errors - error_mark);
        check_mark = checks;
        error_mark = errors;
    endtask

    task automatic test_reg_ops();
        logic [9:0] ops [10];
        ops = '{{`F7_BASE, `F3_ADD}, {`F7_ALT, `F3_ADD}, {`F7_BASE, `F3_AND},
                {`F7_BASE, `F3_OR}, {`F7_BASE, `F3_XOR}, {`F7_BASE, `F3_SLT},
                {`F7_BASE, `F3_SLTU}, {`F7_BASE, `F3_SLL}, {`F7_BASE, `F3_SR},
                {`F7_ALT, `F3_SR}};
        for (int i = 0; i < 10; i++) begin
            for (int j = 0; j < 3; j++) begin
                issue_random(enc_r(ops[i][9:3], 5'd2, 5'd1, ops[i][2:0], 5'd3, `OPC_OP));
            end
        end
        wait_drain();
        finish_test("register ops");
    endtask

    task automatic test_imm_ops();
        logic [5:0]  sh [3];
        logic [63:0] a;
        sh = '{6'd0, 6'd31, 6'd63};
        a  = rnd64();
        issue(enc_i(12'hfff, 5'd1, `F3_ADD, 5'd4, `OPC_OP_IMM), 64'h0, a, 64'h0);
        issue(enc_i(12'h800, 5'd1, `F3_ADD, 5'd4, `OPC_OP_IMM), 64'h0, a, 64'h0);
        issue(enc_i(12'hf9c, 5'd1, `F3_SLT, 5'd4, `OPC_OP_IMM), 64'h0, a, 64'h0);
        issue(enc_i(12'h801, 5'd1, `F3_SLTU, 5'd4, `OPC_OP_IMM), 64'h0, a, 64'h0);
        issue(enc_i(12'hfff, 5'd1, `F3_XOR, 5'd4, `OPC_OP_IMM), 64'h0, a, 64'h0);
        issue(enc_i(12'h8a5, 5'd1, `F3_OR, 5'd4, `OPC_OP_IMM), 64'h0, a, 64'h0);
        issue(enc_i(12'hf0f, 5'd1, `F3_AND, 5'd4, `OPC_OP_IMM), 64'h0, a, 64'h0);
        for (int k = 0; k < 3; k++) begin
            a = rnd64();
            // sign bit set so srai differs from srli
            a[63] = 1'b1;
            issue(enc_i({6'h00, sh[k]}, 5'd1, `F3_SLL, 5'd6, `OPC_OP_IMM), 64'h0, a, 64'h0);
            issue(enc_i({6'h00, sh[k]}, 5'd1, `F3_SR, 5'd6, `OPC_OP_IMM), 64'h0, a, 64'h0);
            issue(enc_i({6'h10, sh[k]}, 5'd1, `F3_SR, 5'd6, `OPC_OP_IMM), 64'h0, a, 64'h0);
        end
        issue(enc_u(20'h80000, 5'd9, `OPC_LUI), 64'h0, a, 64'h0);
        issue(enc_u(20'h12345, 5'd9, `OPC_LUI), 64'h0, a, 64'h0);
        issue(enc_u(20'hfffff, 5'd10, `OPC_AUIPC), 64'h0000_0040_8000_1234, a, 64'h0);
        wait_drain();
        finish_test("immediate ops");
    endtask

    task automatic test_word_ops();
        logic [63:0] a;
        logic [63:0] b;
        logic [4:0]  sh;
        for (int k = 0; k < 2; k++) begin
            a = rnd64();
            b = rnd64();
            a[63:48] = 16'hf0f0;
            a[31]    = 1'b1;
            b[63:48] = 16'h0f0f;
            // bit 5 must be ignored by word shifts
            b[5]     = 1'b1;
            sh       = (k == 0) ? 5'd31 : a[12:8];
            issue(enc_r(`F7_BASE, 5'd2, 5'd1, `F3_ADD, 5'd8, `OPC_OP_32), 64'h0, a, b);
            issue(enc_r(`F7_ALT, 5'd2, 5'd1, `F3_ADD, 5'd8, `OPC_OP_32), 64'h0, a, b);
            issue(enc_r(`F7_BASE, 5'd2, 5'd1, `F3_SLL, 5'd8, `OPC_OP_32), 64'h0, a, b);
            issue(enc_r(`F7_BASE, 5'd2, 5'd1, `F3_SR, 5'd8, `OPC_OP_32), 64'h0, a, b);
            issue(enc_r(`F7_ALT, 5'd2, 5'd1, `F3_SR, 5'd8, `OPC_OP_32), 64'h0, a, b);
            issue(enc_i(12'h9c4, 5'd1, `F3_ADD, 5'd8, `OPC_OP_IMM_32), 64'h0, a, b);
            issue(enc_i({7'h00, sh}, 5'd1, `F3_SLL, 5'd8, `OPC_OP_IMM_32), 64'h0, a, b);
            issue(enc_i({7'h00, sh}, 5'd1, `F3_SR, 5'd8, `OPC_OP_IMM_32), 64'h0, a, b);
            issue(enc_i({7'h20, sh}, 5'd1, `F3_SR, 5'd8, `OPC_OP_IMM_32), 64'h0, a, b);
        end
        wait_drain();
        finish_test("word ops");
    endtask

    task automatic test_writes_illegal();
        issue_random(enc_r(`F7_BASE, 5'd2, 5'd1, `F3_ADD, 5'd0, `OPC_OP));
        issue_random(enc_i(12'h123, 5'd1, `F3_ADD, 5'd0, `OPC_OP_IMM));
        // a load and an unused opcode
        issue_random(enc_i(12'h010, 5'd1, 3'b011, 5'd5, 7'b0000011));
        issue_random(enc_r(7'h7f, 5'd2, 5'd1, 3'b111, 5'd5, 7'b1111111));
        issue_random(enc_r(7'b0000001, 5'd2, 5'd1, `F3_ADD, 5'd5, `OPC_OP));
        issue_random(enc_r(7'b0000001, 5'd2, 5'd1, `F3_SLL, 5'd5, `OPC_OP_32));
        issue_random(enc_i({6'h10, 6'd3}, 5'd1, `F3_SLL, 5'd5, `OPC_OP_IMM));
        issue_random(enc_i({6'h30, 6'd3}, 5'd1, `F3_SR, 5'd5, `OPC_OP_IMM));
        issue_random(enc_i(12'h004, 5'd1, `F3_SLT, 5'd5, `OPC_OP_IMM_32));
        wait_drain();
        finish_test("write enable and illegal");
    endtask

    task automatic test_latency_stream();
        int lat;
        int c0;
        issue_random(enc_r(`F7_BASE, 5'd2, 5'd1, `F3_ADD, 5'd7, `OPC_OP));
        // the accepting edge loads the first of the three slots
        lat = 1;
        @(negedge clk);
        while (!out_valid && lat < 8) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        check_value("latency", 64'd3, 64'(lat));
        wait_drain();
        c0 = cycles;
        for (int i = 0; i < N_BURST; i++) begin
            issue_random(enc_r(`F7_BASE, 5'd2, 5'd1, 3'(i), 5'(i + 1), `OPC_OP));
        end
        wait_drain();
        // three stage registers plus the output transfer edge
        check_value("burst cycles", 64'(N_BURST + 4), 64'(cycles - c0));
        finish_test("latency and streaming");
    endtask

    task automatic test_back_pressure();
        logic [31:0] ins [N_BP_RAND];
        logic [63:0] a [N_BP_RAND];
        logic [63:0] b [N_BP_RAND];
        logic [31:0] r;
        logic        issue_done;
        out_ready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            issue_random(enc_r(`F7_BASE, 5'd2, 5'd1, `F3_XOR, 5'(i + 1), `OPC_OP));
        end
        @(negedge clk);
        check_true(!in_ready, "in_ready stayed high with all three stages full");
        repeat (4) @(negedge clk);
        @(posedge clk);
        #2;
        for (int i = 0; i < N_BP_RAND; i++) begin
            r      = $random(seed);
            ins[i] = enc_r(`F7_BASE, 5'd2, 5'd1, r[2:0], r[10:6], `OPC_OP);
            a[i]   = rnd64();
            b[i]   = rnd64();
        end
        issue_done = 1'b0;
        fork
            begin
                for (int i = 0; i < N_BP_RAND; i++) begin
                    issue(ins[i], 64'h0, a[i], b[i]);
                end
                @(negedge clk);
                issue_done = 1'b1;
            end
            begin
                while (!issue_done) begin
                    r = $random(seed);
                    out_ready = r[0];
                    @(posedge clk);
                    #2;
                end
            end
        join
        out_ready = 1'b1;
        wait_drain();
        finish_test("back-pressure");
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_instr    = '0;
        in_pc       = '0;
        in_rs1_data = '0;
        in_rs2_data = '0;
        out_ready   = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_true(in_ready && !out_valid, "wrong handshake state after reset");
        @(posedge clk);
        #2;
        test_reg_ops();
        test_imm_ops();
        test_word_ops();
        test_writes_illegal();
        test_latency_stream();
        test_back_pressure();
        check_true(exp_q.size() == 0, "instructions still pending at the end");
        $display("summary: %0d passed, %0d failed", checks - errors, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- logic/alu_core.sv
`timescale 1ns/100ps
`include "alu_defines.svh"

module alu_core
    import alu_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  instr_u             in_instr,
    input  logic [`XLEN-1:0]   in_pc,
    input  logic [`XLEN-1:0]   in_rs1_data,
    input  logic [`XLEN-1:0]   in_rs2_data,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [`REG_AW-1:0] out_rd,
    output logic               out_regwrite,
    output logic [`XLEN-1:0]   out_data,
    output logic               out_illegal
);
    dec_exe_if dx ();
    exe_res_if xr ();

    alu_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_instr    (in_instr),
        .in_pc       (in_pc),
        .in_rs1_data (in_rs1_data),
        .in_rs2_data (in_rs2_data),
        .dx          (dx.source)
    );

    alu_execute u_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .dx    (dx.sink),
        .xr    (xr.source)
    );

    alu_result u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .xr           (xr.sink),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_rd       (out_rd),
        .out_regwrite (out_regwrite),
        .out_data     (out_data),
        .out_illegal  (out_illegal)
    );

endmodule

//--- logic/alu_result.sv
`timescale 1ns/100ps
`include "alu_defines.svh"

module alu_result (
    input  logic               clk,
    input  logic               rst_n,
    exe_res_if.sink            xr,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [`REG_AW-1:0] out_rd,
    output logic               out_regwrite,
    output logic [`XLEN-1:0]   out_data,
    output logic               out_illegal
);
    logic [`XLEN-1:0] ext;

    assign ext = xr.word ? {{(`XLEN-32){xr.raw[31]}}, xr.raw[31:0]} : xr.raw;

    assign xr.ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (xr.ready) begin
            out_valid <= xr.valid;
        end
    end

    // x0 is never written
    always_ff @(posedge clk) begin
        if (xr.valid && xr.ready) begin
            out_rd       <= xr.rd;
            out_regwrite <= !xr.illegal && (xr.rd != '0);
            out_data     <= xr.illegal ? '0 : ext;
            out_illegal  <= xr.illegal;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid);

endmodule

//--- logic/alu_execute.sv
`timescale 1ns/100ps
`include "alu_defines.svh"

module alu_execute
    import alu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    dec_exe_if.sink   dx,
    exe_res_if.source xr
);
    logic [`SHAMT_W-1:0] shamt;
    logic [`XLEN-1:0]    sr_src;
    logic [`XLEN-1:0]    raw;

    assign shamt = dx.word ? {{(`SHAMT_W-`SHAMT_W32){1'b0}}, dx.op_b[`SHAMT_W32-1:0]}
                           : dx.op_b[`SHAMT_W-1:0];

    // word right shifts only see the low half of op_a
    always_comb begin
        sr_src = dx.op_a;
        if (dx.word) begin
            if (dx.func == ALU_SR) begin
                sr_src = {{(`XLEN-32){dx.op_a[31]}}, dx.op_a[31:0]};
            end else begin
                sr_src = {{(`XLEN-32){1'b0}}, dx.op_a[31:0]};
            end
        end
    end

    always_comb begin
        case (dx.func)
            ALU_ADD:    raw = dx.op_a + dx.op_b;
            ALU_SUB:    raw = dx.op_a - dx.op_b;
            ALU_AND:    raw = dx.op_a & dx.op_b;
            ALU_OR:     raw = dx.op_a | dx.op_b;
            ALU_XOR:    raw = dx.op_a ^ dx.op_b;
            ALU_LT:     raw = {{(`XLEN-1){1'b0}}, $signed(dx.op_a) < $signed(dx.op_b)};
            ALU_LTU:    raw = {{(`XLEN-1){1'b0}}, dx.op_a < dx.op_b};
            ALU_SL:     raw = dx.op_a << shamt;
            ALU_SRU:    raw = sr_src >> shamt;
            ALU_SR:     raw = $signed(sr_src) >>> shamt;
            ALU_PASS_B: raw = dx.op_b;
            default:    raw = '0;
        endcase
    end

    assign dx.ready = !xr.valid || xr.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xr.valid <= 1'b0;
        end else if (dx.ready) begin
            xr.valid <= dx.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dx.valid && dx.ready) begin
            xr.raw     <= raw;
            xr.word    <= dx.word;
            xr.rd      <= dx.rd;
            xr.illegal <= dx.illegal;
        end
    end

    a_xr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        xr.valid && !xr.ready |=>
            xr.valid && $stable(xr.raw) && $stable(xr.word)
            && $stable(xr.rd) && $stable(xr.illegal));

endmodule

//--- logic/alu_decode.sv
`timescale 1ns/100ps
`include "alu_defines.svh"

module alu_decode
    import alu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  instr_u           in_instr,
    input  logic [`XLEN-1:0] in_pc,
    input  logic [`XLEN-1:0] in_rs1_data,
    input  logic [`XLEN-1:0] in_rs2_data,
    dec_exe_if.source        dx
);
    localparam logic [6:0] F7_BASE_V = `F7_BASE;
    localparam logic [6:0] F7_ALT_V  = `F7_ALT;

    alu_func_e        func;
    logic             word;
    logic             illegal;
    logic             imm_i_sel;
    logic             imm_u_sel;
    logic             pc_sel;
    logic [5:0]       f6;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;

    // funct3 to function for ops with a single encoding
    function automatic alu_func_e f3_func(input logic [2:0] f3);
        alu_func_e f;
        case (f3)
            `F3_SLL:  f = ALU_SL;
            `F3_SLT:  f = ALU_LT;
            `F3_SLTU: f = ALU_LTU;
            `F3_XOR:  f = ALU_XOR;
            `F3_SR:   f = ALU_SRU;
            `F3_OR:   f = ALU_OR;
            `F3_AND:  f = ALU_AND;
            default:  f = ALU_ADD;
        endcase
        return f;
    endfunction

    assign f6    = in_instr.r.funct7[6:1];
    assign imm_i = {{(`XLEN-12){in_instr.i.imm[11]}}, in_instr.i.imm};
    assign imm_u = {{(`XLEN-`ILEN){in_instr.u.imm[19]}}, in_instr.u.imm, 12'b0};

    always_comb begin
        func      = ALU_ADD;
        word      = 1'b0;
        illegal   = 1'b0;
        imm_i_sel = 1'b0;
        imm_u_sel = 1'b0;
        pc_sel    = 1'b0;
        case (in_instr.r.opcode)
            `OPC_OP_IMM: begin
                imm_i_sel = 1'b1;
                case (in_instr.i.funct3)
                    `F3_SLL: begin
                        case (f6)
                            F7_BASE_V[6:1]: func = ALU_SL;
                            default:        illegal = 1'b1;
                        endcase
                    end
                    `F3_SR: begin
                        // shamt[5] sits in bit 25, so only funct6 is checked
                        case (f6)
                            F7_BASE_V[6:1]: func = ALU_SRU;
                            F7_ALT_V[6:1]:  func = ALU_SR;
                            default:        illegal = 1'b1;
                        endcase
                    end
                    default: func = f3_func(in_instr.i.funct3);
                endcase
            end
            `OPC_OP: begin
                case (in_instr.r.funct3)
                    `F3_ADD: begin
                        case (in_instr.r.funct7)
                            `F7_BASE: func = ALU_ADD;
                            `F7_ALT:  func = ALU_SUB;
                            default:  illegal = 1'b1;
                        endcase
                    end
                    `F3_SR: begin
                        case (in_instr.r.funct7)
                            `F7_BASE: func = ALU_SRU;
                            `F7_ALT:  func = ALU_SR;
                            default:  illegal = 1'b1;
                        endcase
                    end
                    default: begin
                        func    = f3_func(in_instr.r.funct3);
                        illegal = (in_instr.r.funct7 != `F7_BASE);
                    end
                endcase
            end
            `OPC_OP_IMM_32, `OPC_OP_32: begin
                word      = 1'b1;
                imm_i_sel = (in_instr.r.opcode == `OPC_OP_IMM_32);
                case (in_instr.r.funct3)
                    `F3_ADD: begin
                        // addiw has no funct7, its immediate sits there
                        if (imm_i_sel) begin
                            func = ALU_ADD;
                        end else begin
                            case (in_instr.r.funct7)
                                `F7_BASE: func = ALU_ADD;
                                `F7_ALT:  func = ALU_SUB;
                                default:  illegal = 1'b1;
                            endcase
                        end
                    end
                    `F3_SLL: begin
                        case (in_instr.r.funct7)
                            `F7_BASE: func = ALU_SL;
                            default:  illegal = 1'b1;
                        endcase
                    end
                    `F3_SR: begin
                        case (in_instr.r.funct7)
                            `F7_BASE: func = ALU_SRU;
                            `F7_ALT:  func = ALU_SR;
                            default:  illegal = 1'b1;
                        endcase
                    end
                    default: illegal = 1'b1;
                endcase
            end
            `OPC_LUI: begin
                imm_u_sel = 1'b1;
                func      = ALU_PASS_B;
            end
            `OPC_AUIPC: begin
                imm_u_sel = 1'b1;
                pc_sel    = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            func = ALU_ADD;
            word = 1'b0;
        end
    end

    assign op_a = illegal ? '0 : (pc_sel ? in_pc : in_rs1_data);
    assign op_b = illegal   ? '0 :
                  imm_u_sel ? imm_u :
                  imm_i_sel ? imm_i : in_rs2_data;

    assign in_ready = !dx.valid || dx.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dx.valid <= 1'b0;
        end else if (in_ready) begin
            dx.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dx.func    <= func;
            dx.word    <= word;
            dx.op_a    <= op_a;
            dx.op_b    <= op_b;
            dx.rd      <= in_instr.r.rd;
            dx.illegal <= illegal;
        end
    end

    // illegal slots carry a harmless add of zeros downstream
    a_illegal_zero: assert property (@(posedge clk) disable iff (!rst_n)
        dx.valid && dx.illegal |->
            dx.func == ALU_ADD && !dx.word && dx.op_a == '0 && dx.op_b == '0);

endmodule

//--- logic/exe_res_if.sv
`timescale 1ns/100ps
`include "alu_defines.svh"

interface exe_res_if;
    logic               valid;
    logic               ready;
    // alu output before word sign extension
    logic [`XLEN-1:0]   raw;
    logic               word;
    logic [`REG_AW-1:0] rd;
    logic               illegal;

    modport source (
        output valid, raw, word, rd, illegal,
        input  ready
    );

    modport sink (
        input  valid, raw, word, rd, illegal,
        output ready
    );

endinterface

//--- logic/dec_exe_if.sv
`timescale 1ns/100ps
`include "alu_defines.svh"

interface dec_exe_if
    import alu_pkg::*;
();
    logic               valid;
    logic               ready;
    alu_func_e          func;
    // 32-bit word op
    logic               word;
    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   op_b;
    logic [`REG_AW-1:0] rd;
    logic               illegal;

    modport source (
        output valid, func, word, op_a, op_b, rd, illegal,
        input  ready
    );

    modport sink (
        input  valid, func, word, op_a, op_b, rd, illegal,
        output ready
    );

endinterface

//--- logic/alu_pkg.sv
`include "alu_defines.svh"

package alu_pkg;

    // one instruction word, read per format
    typedef union packed {
        struct packed {
            logic [6:0]         funct7;
            logic [`REG_AW-1:0] rs2;
            logic [`REG_AW-1:0] rs1;
            logic [2:0]         funct3;
            logic [`REG_AW-1:0] rd;
            logic [6:0]         opcode;
        } r;
        struct packed {
            logic [11:0]        imm;
            logic [`REG_AW-1:0] rs1;
            logic [2:0]         funct3;
            logic [`REG_AW-1:0] rd;
            logic [6:0]         opcode;
        } i;
        struct packed {
            logic [19:0]        imm;
            logic [`REG_AW-1:0] rd;
            logic [6:0]         opcode;
        } u;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LT,
        ALU_LTU,
        ALU_SL,
        ALU_SRU,
        ALU_SR,
        ALU_PASS_B
    } alu_func_e;

endpackage

//--- logic/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// datapath widths
`define XLEN      64
`define ILEN      32
`define REG_AW    5
`define SHAMT_W   6
`define SHAMT_W32 5

// major opcodes
`define OPC_OP_IMM    7'b0010011
`define OPC_OP        7'b0110011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_OP_32     7'b0111011
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111

// funct3
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// funct7, ALT selects SUB and SRA
`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000

`endif
